//--- Bender.yml
package:
  name: eg_gen

sources:
  - eg_pkg.sv
  - eg_delay.sv
  - eg_counter.sv
  - eg_state.sv
  - eg_rate.sv
  - eg_step.sv
  - eg_top.sv
  - target: test
    files:
      - eg_tb_clk.sv
      - eg_tb.sv

//--- all.f
eg_pkg.sv
eg_delay.sv
eg_counter.sv
eg_state.sv
eg_rate.sv
eg_step.sv
eg_top.sv
eg_tb_clk.sv
eg_tb.sv

//--- eg_counter.sv
`timescale 1ns/1ns
`default_nettype none

// global envelope counter, one tick every three samples
module eg_counter (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     zero,   // one pulse per sample, slot 0
	output logic [eg_pkg::CNT_W-1:0] eg_cnt
);

	logic [1:0] pre; // mod-3 prescaler

	always_ff @(posedge clk) begin
		if (rst) begin
			pre    <= 2'd0;
			eg_cnt <= '0;
		end else if (zero) begin
			// third sample pulse
			if (pre == 2'd2) begin
				pre    <= 2'd0;
				eg_cnt <= eg_cnt + 1'b1; // free running, wraps
			end else begin
				pre <= pre + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- eg_delay.sv
`timescale 1ns/1ns
`default_nettype none

// plain shift register, used for the slot rings and input alignment
module eg_delay #(
	parameter int WIDTH  = 1,
	parameter int STAGES = 1
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [WIDTH-1:0] rst_val, // loaded into every entry during reset
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	logic [WIDTH-1:0] sr [STAGES];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < STAGES; i++) sr[i] <= rst_val; // flush whole ring
		end else begin
			for (int i = STAGES-1; i > 0; i--) sr[i] <= sr[i-1];
			sr[0] <= din;
		end
	end

	assign dout = sr[STAGES-1]; // oldest entry

endmodule

`default_nettype wire

//--- eg_pkg.sv
`default_nettype none

package eg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// envelope states

	localparam int STATE_W = 2; // 2 bits per slot in the state ring

	localparam logic [STATE_W-1:0] ST_ATTACK  = 2'd0;
	localparam logic [STATE_W-1:0] ST_DECAY1  = 2'd1; // down to sustain level
	localparam logic [STATE_W-1:0] ST_DECAY2  = 2'd2; // sustain slope
	localparam logic [STATE_W-1:0] ST_RELEASE = 2'd3; // after key off, also idle

	////////////////////////////////////////////////////////////////////////////
	// widths

	// attenuation, 1 lsb ~ 0.094 dB
	localparam int EG_W   = 10;
	localparam int RATE_W = 6;  // effective rate 0..63
	localparam int CFG_W  = 5;  // configured rate before key scaling
	localparam int CNT_W  = 15; // global envelope counter

	// full attenuation, also the idle level
	localparam logic [EG_W-1:0] EG_MAX = 10'd1023;

	////////////////////////////////////////////////////////////////////////////
	// pipeline

	// register stages from slot inputs to level write-back
	// ring delay = NUM_SLOTS - PIPE_DEPTH
	localparam int PIPE_DEPTH = 5;

endpackage

`default_nettype wire

//--- eg_rate.sv
`timescale 1ns/1ns
`default_nettype none

// stages 2 to 4: effective rate, counter bits and step decision
module eg_rate (
	input  logic                       clk,
	input  logic [eg_pkg::STATE_W-1:0] state_in,
	input  logic [eg_pkg::CFG_W-1:0]   cfg,
	input  logic [1:0]                 ks,       // key scale, aligned to cfg
	input  logic [4:0]                 keycode,
	input  logic [eg_pkg::CNT_W-1:0]   eg_cnt,
	input  logic                       cnt_last, // counter lsb from last visit
	output logic [eg_pkg::RATE_W-1:0]  rate,
	output logic                       step,
	output logic                       sum_up,
	output logic                       cnt_lsb,
	output logic [eg_pkg::STATE_W-1:0] state_out,
	input  logic [eg_pkg::EG_W-1:0]    eg_in,
	output logic [eg_pkg::EG_W-1:0]    eg_pass
);

	logic [6:0]                 pre_rate; // one bit of headroom before clamp
	logic [4:0]                 kc_sh;
	logic [eg_pkg::RATE_W-1:0]  rate_c;
	logic [eg_pkg::RATE_W-1:0]  rate_s2, rate_s3;
	logic [eg_pkg::STATE_W-1:0] state_s2, state_s3;
	logic [eg_pkg::EG_W-1:0]    eg_s2, eg_s3;
	logic [3:0]                 r4;   // rate / 4
	logic [3:0]                 lo;   // lowest counter bit taken
	logic [eg_pkg::CNT_W-1:0]   cnt_shift;
	logic [2:0]                 cnt_s3;
	logic [7:0]                 pattern;
	logic                       step_c;

	////////////////////////////////////////////////////////////////////////////
	// stage 2: rate = 2*cfg + keycode >> (3-ks)

	always_comb begin
		kc_sh    = keycode >> (2'd3 - ks);
		pre_rate = {1'b0, cfg, 1'b0} + {2'b00, kc_sh};
		if (cfg == '0)
			rate_c = '0; // rate 0 stays still whatever the keycode
		else if (pre_rate[6])
			rate_c = 6'd63; // clamp
		else
			rate_c = pre_rate[5:0];
	end

	always_ff @(posedge clk) begin
		rate_s2  <= rate_c;
		state_s2 <= state_in;
		eg_s2    <= eg_in;
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 3: pick 3 counter bits, faster rates look at lower bits

	always_comb begin
		r4 = rate_s2[5:2];
		if (state_s2 == eg_pkg::ST_ATTACK)
			lo = (r4 >= 4'd10) ? 4'd0 : 4'd10 - r4; // attack one bit lower
		else
			lo = (r4 >= 4'd11) ? 4'd0 : 4'd11 - r4;
		cnt_shift = eg_cnt >> lo;
	end

	always_ff @(posedge clk) begin
		cnt_s3   <= cnt_shift[2:0];
		rate_s3  <= rate_s2;
		state_s3 <= state_s2;
		eg_s3    <= eg_s2;
	end

	assign cnt_lsb = cnt_s3[0]; // into the per-slot lsb ring

	////////////////////////////////////////////////////////////////////////////
	// stage 4: step pattern lookup

	always_comb begin
		if (rate_s3[5:4] == 2'b11) begin
			// 48+ here step selects the doubled increment
			if (rate_s3[5:2] == 4'hf && state_s3 == eg_pkg::ST_ATTACK)
				pattern = 8'b1111_1111; // 60..63 attack every time
			else begin
				case (rate_s3[1:0])
					2'd0: pattern = 8'b0000_0000;
					2'd1: pattern = 8'b1000_1000;
					2'd2: pattern = 8'b1010_1010;
					default: pattern = 8'b1110_1110;
				endcase
			end
		end else begin
			case (rate_s3[1:0])
				2'd0: pattern = 8'b1010_1010; // 4 of 8
				2'd1: pattern = 8'b1110_1010; // 5
				2'd2: pattern = 8'b1110_1110; // 6
				default: pattern = 8'b1111_1110; // 7
			endcase
		end
		// rates 0 and 1 never step
		step_c = (rate_s3[5:1] == 5'd0) ? 1'b0 : pattern[cnt_s3];
	end

	always_ff @(posedge clk) begin
		step      <= step_c;
		sum_up    <= cnt_s3[0] != cnt_last; // counter moved since last visit
		rate      <= rate_s3;
		state_out <= state_s3;
		eg_pass   <= eg_s3;
	end

endmodule

`default_nettype wire

//--- eg_state.sv
`timescale 1ns/1ns
`default_nettype none

// stage 1: key edges, state progression and rate select
module eg_state (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       key_on,
	input  logic                       key_last,  // key_on from this slot's last visit
	input  logic [eg_pkg::STATE_W-1:0] state_in,  // from state ring
	input  logic [eg_pkg::EG_W-1:0]    eg_in,     // from level ring
	input  logic [eg_pkg::CFG_W-1:0]   arate,
	input  logic [eg_pkg::CFG_W-1:0]   d1rate,
	input  logic [eg_pkg::CFG_W-1:0]   d2rate,
	input  logic [3:0]                 rrate,
	input  logic [3:0]                 sl,
	output logic [eg_pkg::STATE_W-1:0] state_out,
	output logic [eg_pkg::CFG_W-1:0]   cfg,
	output logic [eg_pkg::EG_W-1:0]    eg_pass,
	output logic                       pg_rst
);

	logic       key_now; // rising edge of key_on
	logic       key_off; // falling edge
	logic [4:0] sl_lvl;  // sustain level vs top 5 level bits

	assign key_now = key_on & ~key_last;
	assign key_off = ~key_on & key_last;
	assign sl_lvl  = (sl == 4'd15) ? 5'd31 : {1'b0, sl}; // 15 means ~93 dB

	always_ff @(posedge clk) begin
		if (rst) begin
			state_out <= eg_pkg::ST_RELEASE;
			cfg       <= '0;
			pg_rst    <= 1'b0;
		end else begin
			// phase reset on key on, and while fully attenuated
			pg_rst <= key_now | (eg_in == eg_pkg::EG_MAX);
			if (key_off) begin
				state_out <= eg_pkg::ST_RELEASE;
				cfg       <= {rrate, 1'b1}; // release rate is 4 bits
			end else if (key_now) begin
				state_out <= eg_pkg::ST_ATTACK;
				cfg       <= arate;
			end else begin
				case (state_in)
					eg_pkg::ST_ATTACK: begin
						if (eg_in == '0) begin // peak reached
							state_out <= eg_pkg::ST_DECAY1;
							cfg       <= d1rate;
						end else begin
							state_out <= eg_pkg::ST_ATTACK;
							cfg       <= arate;
						end
					end
					eg_pkg::ST_DECAY1: begin
						if (eg_in[eg_pkg::EG_W-1 -: 5] >= sl_lvl) begin
							state_out <= eg_pkg::ST_DECAY2;
							cfg       <= d2rate;
						end else begin
							state_out <= eg_pkg::ST_DECAY1;
							cfg       <= d1rate;
						end
					end
					eg_pkg::ST_DECAY2: begin
						state_out <= eg_pkg::ST_DECAY2;
						cfg       <= d2rate;
					end
					default: begin // release holds until next key on
						state_out <= eg_pkg::ST_RELEASE;
						cfg       <= {rrate, 1'b1};
					end
				endcase
			end
		end
	end

	// level travels along, no change here
	always_ff @(posedge clk) eg_pass <= eg_in;

endmodule

`default_nettype wire

//--- eg_step.sv
`timescale 1ns/1ns
`default_nettype none

// stages 5 and 6 update the level and add total level on the way out
module eg_step (
	input  logic                       clk,
	input  logic [eg_pkg::STATE_W-1:0] state_in,
	input  logic [eg_pkg::RATE_W-1:0]  rate,
	input  logic                       step,
	input  logic                       sum_up,
	input  logic [eg_pkg::EG_W-1:0]    eg_in,
	input  logic [6:0]                 tl,      // aligned to eg_next
	output logic [eg_pkg::EG_W-1:0]    eg_next, // back into the level ring
	output logic [eg_pkg::EG_W-1:0]    eg_out
);

	logic [3:0]              r4;
	logic [2:0]              sh;      // attack shift
	logic [eg_pkg::EG_W-1:0] ar_dec;
	logic [eg_pkg::EG_W-1:0] ar_lvl;
	logic [1:0]              stv;     // step value before scaling
	logic [1:0]              sc;
	logic [4:0]              inc;
	logic [eg_pkg::EG_W:0]   dr_sum;  // carry for saturation
	logic [eg_pkg::EG_W-1:0] dr_lvl;
	logic [eg_pkg::EG_W+1:0] out_sum;

	////////////////////////////////////////////////////////////////////////////
	// attack approaches 0 exponentially

	always_comb begin
		r4 = rate[5:2];
		if (r4 >= 4'd14)
			sh = 3'd2;
		else if (r4 == 4'd13)
			sh = 3'd3;
		else
			sh = 3'd4;
		ar_dec = (eg_in >> sh) + 1'b1; // shifted level plus 1 never overflows
		ar_lvl = (ar_dec >= eg_in) ? '0 : eg_in - ar_dec;
	end

	////////////////////////////////////////////////////////////////////////////
	// decay and release add a linear increment

	always_comb begin
		// from 48 up a step moves by 2 and no step by 1
		if (rate[5:4] == 2'b11)
			stv = {step, ~step};
		else
			stv = {1'b0, step};
		sc     = (r4 <= 4'd12) ? 2'd0 : 2'(r4 - 4'd12); // x1 x2 x4 x8
		inc    = {3'b000, stv} << sc;
		dr_sum = {1'b0, eg_in} + {6'd0, inc};
		dr_lvl = (dr_sum > {1'b0, eg_pkg::EG_MAX}) ? eg_pkg::EG_MAX : dr_sum[eg_pkg::EG_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (!sum_up)
			eg_next <= eg_in; // counter idle for this slot
		else if (state_in == eg_pkg::ST_ATTACK) begin
			if (rate[5:1] == 5'd31)
				eg_next <= '0; // instant attack at 62 and 63
			else if (step)
				eg_next <= ar_lvl;
			else
				eg_next <= eg_in;
		end else
			eg_next <= dr_lvl;
	end

	////////////////////////////////////////////////////////////////////////////
	// total level adds 8 level lsb per tl step

	assign out_sum = {2'b00, eg_next} + {2'b00, tl, 3'b000};

	always_ff @(posedge clk)
		eg_out <= (out_sum > {2'b00, eg_pkg::EG_MAX}) ? eg_pkg::EG_MAX
			: out_sum[eg_pkg::EG_W-1:0];

endmodule

`default_nettype wire

//--- eg_tb.sv
`timescale 1ns/1ns
`default_nettype none

// slot-serial envelope generator testbench with random slots and a behavioral model
module eg_tb;

	localparam int N    = 24;
	localparam int ATT  = eg_pkg::ST_ATTACK;
	localparam int D1   = eg_pkg::ST_DECAY1;
	localparam int D2   = eg_pkg::ST_DECAY2;
	localparam int REL  = eg_pkg::ST_RELEASE;
	localparam int MAXL = eg_pkg::EG_MAX;

	logic       clk, rst, zero, key_on, pg_rst;
	logic [4:0] arate, d1rate, d2rate, keycode;
	logic [3:0] rrate, sl;
	logic [1:0] ks;
	logic [6:0] tl;
	logic [9:0] eg_out;

	// per-slot stimulus held until a test changes it
	logic [4:0] c_ar [N], c_d1 [N], c_d2 [N], c_kc [N];
	logic [3:0] c_rr [N], c_sl [N];
	logic [1:0] c_ks [N];
	logic [6:0] c_tl [N];
	logic       key [N];
	logic [9:0] last_out [N]; // dut eg_out from each slot's last visit

	// model state
	int m_st [N], m_lvl [N], m_lsb [N];
	bit m_key [N];
	int m_cnt, m_pre;
	int q_slot [$], q_exp [$];
	bit q_mono [$];

	logic [31:0] seed;
	int    slot, errs, err0, cur_test, npass, nfail;
	bit    pend;
	string tname;

	eg_tb_clk i_clk (.clk(clk));

	eg_top #(.NUM_SLOTS(N)) i_dut (
		.clk(clk), .rst(rst), .zero(zero), .key_on(key_on),
		.arate(arate), .d1rate(d1rate), .d2rate(d2rate), .rrate(rrate), .sl(sl),
		.ks(ks), .keycode(keycode), .tl(tl), .eg_out(eg_out), .pg_rst(pg_rst)
	);

	////////////////////////////////////////////////////////////////////////////
	// random numbers and model

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223; // lcg
		return seed;
	endfunction

	function automatic int rnd(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:16]) % n; // upper bits have the longer period
	endfunction

	// one bit per selected counter value
	function automatic bit step_of(input int rate, input int bits, input bit att);
		logic [7:0] pat;
		if (rate < 2)
			return 1'b0;
		if (rate >= 60 && att)
			return 1'b1;
		case (rate % 4)
			0: pat = (rate < 48) ? 8'haa : 8'h00;
			1: pat = (rate < 48) ? 8'hea : 8'h88;
			2: pat = (rate < 48) ? 8'hee : 8'haa;
			default: pat = (rate < 48) ? 8'hfe : 8'hee;
		endcase
		return pat[bits];
	endfunction

	task automatic count_zero(); // mod-3 prescaler
		if (m_pre == 2) begin
			m_pre = 0;
			m_cnt = (m_cnt + 1) % 32768;
		end else
			m_pre++;
	endtask

	// one slot visit on the inputs still driven for it
	task automatic model_visit(input int s, output bit pg, output int out,
		output int st0, output int st);
		bit kon, koff, stp, up;
		int cfg, rate, r4, lo, bits, sh, dec, inc, lvl, slv;
		kon  = key_on && !m_key[s];
		koff = !key_on && m_key[s];
		lvl  = m_lvl[s];
		st0  = m_st[s];
		st   = st0;
		slv  = (sl == 4'd15) ? 31 : int'(sl);
		pg   = kon || lvl == MAXL;
		if (koff)
			st = REL;
		else if (kon)
			st = ATT;
		else if (st == ATT && lvl == 0)
			st = D1;
		else if (st == D1 && (lvl >> 5) >= slv)
			st = D2;
		case (st)
			ATT: cfg = int'(arate);
			D1: cfg = int'(d1rate);
			D2: cfg = int'(d2rate);
			default: cfg = int'(rrate) * 2 + 1;
		endcase
		rate = (cfg == 0) ? 0 : cfg * 2 + (int'(keycode) >> (3 - int'(ks)));
		if (rate > 63)
			rate = 63;
		r4 = rate / 4;
		lo = (st == ATT) ? 10 - r4 : 11 - r4; // attack one bit lower
		if (lo < 0)
			lo = 0;
		bits = (m_cnt >> lo) % 8;
		stp  = step_of(rate, bits, st == ATT);
		up   = (bits % 2) != m_lsb[s]; // counter moved since last visit
		m_lsb[s] = bits % 2;
		if (up && st == ATT) begin
			if (rate >= 62)
				lvl = 0;
			else if (stp) begin
				sh  = (r4 >= 14) ? 2 : (r4 == 13) ? 3 : 4;
				dec = (lvl >> sh) + 1;
				lvl = (dec >= lvl) ? 0 : lvl - dec;
			end
		end else if (up) begin
			if (rate >= 48)
				inc = stp ? 2 : 1; // doubled increment from 48 up
			else
				inc = stp ? 1 : 0;
			if (r4 > 12)
				inc = inc << (r4 - 12);
			lvl = (lvl + inc > MAXL) ? MAXL : lvl + inc;
		end
		m_lvl[s] = lvl;
		m_st[s]  = st;
		m_key[s] = key_on;
		out = (lvl + int'(tl) * 8 > MAXL) ? MAXL : lvl + int'(tl) * 8;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus and checks

	task automatic fail_val(input string what, input int s, input int exp,
		input logic [31:0] act);
		$display("[FAIL] %s slot %0d %s expected %0d actual %0d", tname, s, what, exp, act);
		errs++;
	endtask

	task automatic drive(input int s);
		zero    = (s == 0); // slot 0 marker
		key_on  = key[s];
		arate   = c_ar[s];
		d1rate  = c_d1[s];
		d2rate  = c_d2[s];
		rrate   = c_rr[s];
		sl      = c_sl[s];
		ks      = c_ks[s];
		keycode = c_kc[s];
		tl      = c_tl[s];
	endtask

	// models and checks the slot in flight, then drives the next one
	task automatic tick();
		int nxt, out, st0, st1, s, e;
		bit pg, mono;
		@(negedge clk);
		nxt = (slot + 1) % N;
		if (nxt == 0)
			count_zero(); // counter as stage 3 will see it
		if (pend) begin
			model_visit(slot, pg, out, st0, st1);
			if (pg_rst !== pg)
				fail_val("pg_rst", slot, int'(pg), 32'(pg_rst));
			if (cur_test == 3 && st0 == D1 && (st1 == D1 || st1 == D2)
				&& ((int'(last_out[slot][9:5]) >= ((sl == 4'd15) ? 31 : int'(sl)))
				!= (st1 == D2))) begin
				$display("%s: slot %0d left decay 1 away from its sustain level", tname, slot);
				errs++;
			end
			mono = (cur_test == 3 && (st0 == D1 || st0 == D2) && (st1 == D1 || st1 == D2))
				|| (cur_test == 4 && st0 == REL && st1 == REL);
			q_slot.push_back(slot);
			q_exp.push_back(out);
			q_mono.push_back(mono);
		end
		if (q_exp.size() == 6) begin // eg_out lags 6 cycles
			s    = q_slot.pop_front();
			e    = q_exp.pop_front();
			mono = q_mono.pop_front();
			if (eg_out !== 10'(e))
				fail_val("eg_out", s, e, 32'(eg_out));
			if (mono && eg_out < last_out[s]) begin
				$display("%s: slot %0d output fell from %0d to %0d", tname, s, last_out[s], eg_out);
				errs++;
			end
			last_out[s] = eg_out;
		end
		if (cur_test == 6 && rnd(16) == 0)
			key[nxt] = !key[nxt]; // random key on and off
		slot = nxt;
		pend = 1'b1;
		drive(slot);
	endtask

	task automatic run_rounds(input int n);
		repeat (n * N) tick();
	endtask

	task automatic new_config(input int s);
		c_ar[s] = 5'(rnd(32));
		c_d1[s] = 5'(rnd(32));
		c_d2[s] = 5'(rnd(32));
		c_rr[s] = 4'(rnd(16));
		c_sl[s] = 4'(rnd(16));
		c_ks[s] = 2'(rnd(4));
		c_kc[s] = 5'(rnd(32));
		c_tl[s] = 7'(rnd(128));
	endtask

	function automatic bit all_max();
		for (int s = 0; s < N; s++)
			if (last_out[s] !== 10'(MAXL))
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic start_test(input string name, input int id);
		tname    = name;
		cur_test = id;
		err0     = errs;
	endtask

	task automatic end_test();
		if (errs == err0) begin
			npass++;
			$display("%s passed", tname);
		end else begin
			nfail++;
			$display("%s failed with %0d errors", tname, errs - err0);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		int n;
		seed     = 32'h62eb_dffa;
		errs     = 0;
		err0     = 0;
		cur_test = 0;
		npass    = 0;
		nfail    = 0;
		m_cnt    = 0;
		m_pre    = 0;
		slot = N - 1; // first drive is slot 0
		pend = 1'b0;
		rst  = 1'b1;
		for (int s = 0; s < N; s++) begin
			key[s]      = 1'b0;
			new_config(s);
			m_st[s]     = REL; // rings come out of reset idle
			m_lvl[s]    = MAXL;
			m_key[s]    = 1'b0;
			m_lsb[s]    = 0;
			last_out[s] = 10'(MAXL);
		end
		drive(0);
		zero = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		start_test("reset_idle", 1);
		run_rounds(2);
		end_test();

		start_test("attack_to_zero", 2);
		c_ar[3] = 5'd31; // instant attack
		c_d1[3] = 5'd0;
		c_d2[3] = 5'd0;
		c_sl[3] = 4'd0;
		c_tl[3] = 7'd20;
		key[3]  = 1'b1;
		n = 0;
		while (last_out[3] !== 10'd160 && n < 50 * N) begin
			tick();
			n++;
		end
		if (last_out[3] !== 10'd160) begin
			$display("attack_to_zero: slot 3 did not reach zero level in time");
			errs++;
		end
		end_test();

		start_test("decay_sustain", 3);
		for (int s = 0; s < N; s++)
			key[s] = 1'b0;
		run_rounds(1); // key off first, so every slot sees an edge
		for (int s = 0; s < N; s++) begin
			new_config(s);
			c_ar[s] = 5'd31;
			c_tl[s] = 7'd0; // eg_out is the level
			key[s]  = 1'b1;
		end
		run_rounds(60);
		end_test();

		start_test("release", 4);
		for (int s = 0; s < N; s++) begin
			c_rr[s] = 4'(14 + rnd(2));
			key[s]  = 1'b0;
		end
		n = 0;
		while (!all_max() && n < 800 * N) begin
			tick();
			n++;
		end
		if (!all_max()) begin
			$display("release: not every slot reached full attenuation in time");
			errs++;
		end
		end_test();

		start_test("key_scaling", 5);
		for (int s = 0; s < N; s++) begin
			c_ar[s] = 5'd20; // same rates with different scaling
			c_d1[s] = 5'd12;
			c_d2[s] = 5'd6;
			c_sl[s] = 4'd15;
			c_ks[s] = 2'(rnd(4));
			c_kc[s] = 5'(rnd(32));
			key[s]  = 1'b1;
		end
		run_rounds(150);
		end_test();

		start_test("random_mix", 6);
		for (int s = 0; s < N; s++)
			new_config(s);
		run_rounds(200);
		end_test();

		$display("tests passed %0d failed %0d", npass, nfail);
		if (nfail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- eg_tb_clk.sv
`timescale 1ns/1ns
`default_nettype none

// free-running testbench clock, 4 ns period
module eg_tb_clk (
	output logic clk
);

	initial clk = 1'b0;

	always #2 clk = ~clk; // half period

endmodule

`default_nettype wire

//--- eg_top.sv
`timescale 1ns/1ns
`default_nettype none

// slot-serial envelope generator, one slot per clock
module eg_top #(
	parameter int NUM_SLOTS = 24
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       zero,    // slot 0 marker
	input  logic       key_on,
	input  logic [4:0] arate,
	input  logic [4:0] d1rate,
	input  logic [4:0] d2rate,
	input  logic [3:0] rrate,
	input  logic [3:0] sl,
	input  logic [1:0] ks,
	input  logic [4:0] keycode,
	input  logic [6:0] tl,
	output logic [9:0] eg_out,  // 6 cycles after slot inputs
	output logic       pg_rst   // 1 cycle after slot inputs
);

	localparam int RING = NUM_SLOTS - eg_pkg::PIPE_DEPTH; // level ring depth

	logic [eg_pkg::STATE_W-1:0] state_ring; // ring tail, stage 1
	logic [eg_pkg::EG_W-1:0]    eg_ring;
	logic                       key_last;
	logic                       cnt_last;
	logic [eg_pkg::STATE_W-1:0] s1_state, s4_state;
	logic [eg_pkg::CFG_W-1:0]   s1_cfg;
	logic [eg_pkg::EG_W-1:0]    s1_eg, s4_eg, eg_next;
	logic [1:0]                 ks_d;
	logic [4:0]                 keycode_d;
	logic [6:0]                 tl_d;
	logic [eg_pkg::CNT_W-1:0]   eg_cnt;
	logic [eg_pkg::RATE_W-1:0]  rate;
	logic                       step, sum_up, cnt_lsb;

	////////////////////////////////////////////////////////////////////////////
	// input alignment

	eg_delay #(.WIDTH(2), .STAGES(1)) u_ks_d (
		.clk(clk), .rst(rst), .rst_val(2'd0), .din(ks), .dout(ks_d)
	);

	eg_delay #(.WIDTH(5), .STAGES(1)) u_kc_d (
		.clk(clk), .rst(rst), .rst_val(5'd0), .din(keycode), .dout(keycode_d)
	);

	// tl meets eg_next at stage 5
	eg_delay #(.WIDTH(7), .STAGES(eg_pkg::PIPE_DEPTH)) u_tl_d (
		.clk(clk), .rst(rst), .rst_val(7'd0), .din(tl), .dout(tl_d)
	);

	////////////////////////////////////////////////////////////////////////////
	// pipeline

	eg_counter u_cnt (.clk(clk), .rst(rst), .zero(zero), .eg_cnt(eg_cnt));

	eg_state u_state (
		.clk(clk), .rst(rst), .key_on(key_on), .key_last(key_last),
		.state_in(state_ring), .eg_in(eg_ring),
		.arate(arate), .d1rate(d1rate), .d2rate(d2rate), .rrate(rrate), .sl(sl),
		.state_out(s1_state), .cfg(s1_cfg), .eg_pass(s1_eg), .pg_rst(pg_rst)
	);

	eg_rate u_rate (
		.clk(clk), .state_in(s1_state), .cfg(s1_cfg), .ks(ks_d), .keycode(keycode_d),
		.eg_cnt(eg_cnt), .cnt_last(cnt_last),
		.rate(rate), .step(step), .sum_up(sum_up), .cnt_lsb(cnt_lsb),
		.state_out(s4_state), .eg_in(s1_eg), .eg_pass(s4_eg)
	);

	eg_step u_step (
		.clk(clk), .state_in(s4_state), .rate(rate), .step(step), .sum_up(sum_up),
		.eg_in(s4_eg), .tl(tl_d), .eg_next(eg_next), .eg_out(eg_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// rings, each slot back at stage 1 after NUM_SLOTS cycles

	// level leaves at stage 5
	eg_delay #(.WIDTH(eg_pkg::EG_W), .STAGES(RING)) u_eg_ring (
		.clk(clk), .rst(rst), .rst_val(eg_pkg::EG_MAX), .din(eg_next), .dout(eg_ring)
	);

	// state leaves at stage 4, so one entry more
	eg_delay #(.WIDTH(eg_pkg::STATE_W), .STAGES(RING + 1)) u_st_ring (
		.clk(clk), .rst(rst), .rst_val(eg_pkg::ST_RELEASE),
		.din(s4_state), .dout(state_ring)
	);

	eg_delay #(.WIDTH(1), .STAGES(NUM_SLOTS)) u_key_ring (
		.clk(clk), .rst(rst), .rst_val(1'b0), .din(key_on), .dout(key_last)
	);

	eg_delay #(.WIDTH(1), .STAGES(NUM_SLOTS)) u_lsb_ring ( // per-slot counter lsb
		.clk(clk), .rst(rst), .rst_val(1'b0), .din(cnt_lsb), .dout(cnt_last)
	);

endmodule

`default_nettype wire
